/* verilog/mulPkg.sv */
package mulPkg;

    localparam int OP_W        = 32;
    localparam int PROD_W      = 64;
    localparam int NUM_PP      = 16;
    localparam int TAG_W       = 4;
    localparam int FIFO_DEPTH  = 4;
    localparam int OUT_CREDITS = 2;
    localparam int PTR_W       = $clog2(FIFO_DEPTH);
    localparam int CNT_W       = $clog2(FIFO_DEPTH) + 1;   // Holds 0..FIFO_DEPTH
    localparam int CSA_LEVELS  = 6;                        // 16-11-8-6-4-3-2

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [OP_W-1:0]  op1;                             // Multiplicand
        logic [OP_W-1:0]  op2;                             // Multiplier
    } mulReq_t;

    typedef struct packed {
        logic                           valid;
        logic [TAG_W-1:0]               tag;
        logic [NUM_PP-1:0][PROD_W-1:0]  pp;
    } ppBundle_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [PROD_W-1:0] sum;
        logic [PROD_W-1:0] carry;
    } csaPair_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [PROD_W-1:0] product;
    } mulResp_t;

endpackage

/* verilog/boothEncoder.sv */
`timescale 1ns/1ps

module boothEncoder (
    input  logic [2:0]                grp,    // Multiplier bits 2i+1, 2i, 2i-1
    input  logic [3:0]                gid,    // Group index
    input  logic [mulPkg::OP_W-1:0]   op1,    // Multiplicand
    output logic [mulPkg::PROD_W-1:0] pp
);

    logic [mulPkg::PROD_W-1:0] op1Ex;
    logic [mulPkg::PROD_W-1:0] mag;
    logic [mulPkg::PROD_W-1:0] digitPp;
    logic                      neg;
    logic                      selOne;
    logic                      selTwo;

    assign op1Ex = {{(mulPkg::PROD_W - mulPkg::OP_W){op1[mulPkg::OP_W-1]}}, op1};

    // Digit table
    //   000, 111 -> 0
    //   001, 010 -> +1    101, 110 -> -1
    //   011      -> +2    100      -> -2
    assign neg    = grp[2];
    assign selOne = grp[1] ^ grp[0];
    assign selTwo = (grp == 3'b011) || (grp == 3'b100);

    always_comb begin
        if (selTwo) begin
            mag = {op1Ex[mulPkg::PROD_W-2:0], 1'b0};
        end else if (selOne) begin
            mag = op1Ex;
        end else begin
            mag = '0;
        end
    end

    assign digitPp = neg ? (~mag + 1'b1) : mag;      // -0 stays 0
    assign pp      = digitPp << {gid, 1'b0};          // Weight 4^gid

endmodule

/* verilog/ppGenStage.sv */
`timescale 1ns/1ps

module ppGenStage (
    input  logic              clk,
    input  logic              rstN,
    input  mulPkg::mulReq_t   req,
    output mulPkg::ppBundle_t ppOut
);

    logic [mulPkg::OP_W:0]                               op2Ext;
    logic [mulPkg::NUM_PP-1:0][mulPkg::PROD_W-1:0]       ppComb;

    assign op2Ext = {req.op2, 1'b0};                   // Implied zero below bit 0

    genvar i;
    generate
        for (i = 0; i < mulPkg::NUM_PP; i++) begin : genBooth
            boothEncoder booth_i (
                .grp (op2Ext[2*i +: 3]),
                .gid (4'(i)),
                .op1 (req.op1),
                .pp  (ppComb[i])
            );
        end
    endgenerate

    always_ff @(posedge clk) begin
        ppOut.tag <= req.tag;
        ppOut.pp  <= ppComb;
        if (!rstN) begin
            ppOut.valid <= 1'b0;
        end else begin
            ppOut.valid <= req.valid;
        end
    end

endmodule

/* verilog/csaTreeStage.sv */
`timescale 1ns/1ps

module csaTreeStage (
    input  logic              clk,
    input  logic              rstN,
    input  mulPkg::ppBundle_t ppIn,
    output mulPkg::csaPair_t  csaOut
);

    logic [mulPkg::PROD_W-1:0] rows [mulPkg::NUM_PP];
    logic [mulPkg::PROD_W-1:0] nxt  [mulPkg::NUM_PP];
    logic [mulPkg::PROD_W-1:0] opA;
    logic [mulPkg::PROD_W-1:0] opB;
    logic [mulPkg::PROD_W-1:0] opC;
    int                        rowCnt;
    int                        nxtCnt;

    // Each level compresses every full group of three rows into two,
    // leftover rows pass straight down
    always_comb begin
        for (int k = 0; k < mulPkg::NUM_PP; k++) begin
            rows[k] = ppIn.pp[k];
        end
        rowCnt = mulPkg::NUM_PP;
        opA    = '0;
        opB    = '0;
        opC    = '0;
        for (int lvl = 0; lvl < mulPkg::CSA_LEVELS; lvl++) begin
            nxtCnt = 0;
            for (int k = 0; k < mulPkg::NUM_PP; k++) begin
                nxt[k] = '0;
            end
            for (int g = 0; g < mulPkg::NUM_PP / 3; g++) begin
                if (3 * g + 2 < rowCnt) begin
                    opA             = rows[3*g];
                    opB             = rows[3*g+1];
                    opC             = rows[3*g+2];
                    nxt[nxtCnt]     = opA ^ opB ^ opC;
                    nxt[nxtCnt + 1] = ((opA & opB) | (opA & opC) | (opB & opC)) << 1;
                    nxtCnt          = nxtCnt + 2;
                end
            end
            for (int k = 0; k < mulPkg::NUM_PP; k++) begin
                if (k >= (rowCnt / 3) * 3 && k < rowCnt) begin
                    nxt[nxtCnt] = rows[k];
                    nxtCnt      = nxtCnt + 1;
                end
            end
            rows   = nxt;
            rowCnt = nxtCnt;
        end
    end

    always_ff @(posedge clk) begin
        csaOut.tag   <= ppIn.tag;
        csaOut.sum   <= rows[0];
        csaOut.carry <= rows[1];
        if (!rstN) begin
            csaOut.valid <= 1'b0;
        end else begin
            csaOut.valid <= ppIn.valid;
        end
    end

endmodule

/* verilog/finalAddStage.sv */
`timescale 1ns/1ps

module finalAddStage (
    input  logic             clk,
    input  logic             rstN,
    input  mulPkg::csaPair_t csaIn,
    output mulPkg::mulResp_t prodOut
);

    logic [mulPkg::PROD_W-1:0] cpaSum;

    assign cpaSum = csaIn.sum + csaIn.carry;           // Wraps mod 2^64

    always_ff @(posedge clk) begin
        prodOut.tag     <= csaIn.tag;
        prodOut.product <= cpaSum;
        if (!rstN) begin
            prodOut.valid <= 1'b0;
        end else begin
            prodOut.valid <= csaIn.valid;
        end
    end

endmodule

/* verilog/resultCreditBuffer.sv */
`timescale 1ns/1ps

module resultCreditBuffer (
    input  logic             clk,
    input  logic             rstN,
    input  mulPkg::mulResp_t wrIn,
    input  logic             outCredit,
    output mulPkg::mulResp_t resp,
    output logic             inCredit
);

    mulPkg::mulResp_t mem [mulPkg::FIFO_DEPTH];
    mulPkg::ptr_t     wrPtr;
    mulPkg::ptr_t     rdPtr;
    mulPkg::cnt_t     fillCnt;
    mulPkg::cnt_t     creditCnt;                       // Consumer credits held
    logic             doSend;

    assign doSend = (fillCnt != '0) && (creditCnt != '0);

    always_ff @(posedge clk) begin
        if (wrIn.valid) begin
            mem[wrPtr] <= wrIn;
        end
    end

    always_ff @(posedge clk) begin
        if (doSend) begin
            resp.tag     <= mem[rdPtr].tag;
            resp.product <= mem[rdPtr].product;
        end
        if (!rstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            fillCnt    <= '0;
            creditCnt  <= mulPkg::cnt_t'(mulPkg::OUT_CREDITS);
            resp.valid <= 1'b0;
            inCredit   <= 1'b0;
        end else begin
            if (wrIn.valid) begin
                wrPtr <= wrPtr + mulPkg::ptr_t'(1);
            end
            if (doSend) begin
                rdPtr <= rdPtr + mulPkg::ptr_t'(1);
            end
            fillCnt    <= fillCnt + mulPkg::cnt_t'(wrIn.valid) - mulPkg::cnt_t'(doSend);
            creditCnt  <= creditCnt + mulPkg::cnt_t'(outCredit) - mulPkg::cnt_t'(doSend);
            resp.valid <= doSend;
            inCredit   <= doSend;                      // Slot freed, upstream may send again
        end
    end

endmodule

/* verilog/mulTop.sv */
`timescale 1ns/1ps

module mulTop (
    input  logic             clk,
    input  logic             rstN,
    input  mulPkg::mulReq_t  req,
    input  logic             outCredit,
    output mulPkg::mulResp_t resp,
    output logic             inCredit
);

    mulPkg::ppBundle_t ppBus;
    mulPkg::csaPair_t  csaBus;
    mulPkg::mulResp_t  prodBus;

    ppGenStage ppGen_i (
        .clk   (clk),
        .rstN  (rstN),
        .req   (req),
        .ppOut (ppBus)
    );

    csaTreeStage csaTree_i (
        .clk    (clk),
        .rstN   (rstN),
        .ppIn   (ppBus),
        .csaOut (csaBus)
    );

    finalAddStage finalAdd_i (
        .clk     (clk),
        .rstN    (rstN),
        .csaIn   (csaBus),
        .prodOut (prodBus)
    );

    resultCreditBuffer resBuf_i (
        .clk       (clk),
        .rstN      (rstN),
        .wrIn      (prodBus),
        .outCredit (outCredit),
        .resp      (resp),
        .inCredit  (inCredit)
    );

endmodule

/* dv/mulCredit_checker.sv */
`timescale 1ns/1ps

module mulCredit_checker (
    input logic             clk,
    input logic             rstN,
    input mulPkg::mulResp_t wrIn,
    input logic             outCredit,
    input mulPkg::mulResp_t resp,
    input logic             inCredit,
    input mulPkg::cnt_t     fillCnt,
    input logic             doSend
);

    int failCnt = 0;
    int grantCnt;                                      // Consumer credits not yet used
    int heldCnt;                                       // Results written, credit not yet returned

    always_ff @(posedge clk) begin
        if (!rstN) begin
            grantCnt <= mulPkg::OUT_CREDITS;
            heldCnt  <= 0;
        end else begin
            grantCnt <= grantCnt + int'(outCredit) - int'(resp.valid);
            heldCnt  <= heldCnt + int'(wrIn.valid) - int'(inCredit);
        end
    end

    // Write into a full FIFO only when a pop happens in the same cycle
    noOverflow: assert property (@(posedge clk) disable iff (!rstN)
        wrIn.valid && (int'(fillCnt) >= mulPkg::FIFO_DEPTH) |-> doSend)
        else begin
            $error("Result FIFO written while full");
            failCnt++;
        end

    // Last cycle's outCredit was not yet usable for this send
    respNeedsCredit: assert property (@(posedge clk) disable iff (!rstN)
        resp.valid |-> grantCnt > int'($past(outCredit)))
        else begin
            $error("Result sent with no consumer credit held");
            failCnt++;
        end

    creditForResult: assert property (@(posedge clk) disable iff (!rstN)
        inCredit |-> heldCnt > 0)
        else begin
            $error("Upstream credit returned with no result written");
            failCnt++;
        end

endmodule

/* dv/mulTb.sv */
`timescale 1ns/1ps

module mulTb;

    logic             clk = 1'b0;
    logic             rstN;
    mulPkg::mulReq_t  req;
    logic             outCredit;
    mulPkg::mulResp_t resp;
    logic             inCredit;

    logic [mulPkg::TAG_W-1:0]  expTag  [64];
    logic [mulPkg::OP_W-1:0]   expOp1  [64];
    logic [mulPkg::OP_W-1:0]   expOp2  [64];
    logic [mulPkg::PROD_W-1:0] expProd [64];

    int   seed;
    int   numVec      = 0;
    int   errCnt      = 0;
    int   chkFails    = 0;
    int   upCredits   = mulPkg::FIFO_DEPTH;   // Upstream credit model
    int   respCnt     = 0;
    int   rxCnt       = 0;
    int   creditsSeen = 0;                    // outCredit pulses sampled by the DUT
    int   creditsGiven = 0;
    int   edgeCnt     = 0;
    int   acceptEdge  = 0;
    int   idx;
    logic loaded      = 1'b0;
    logic started     = 1'b0;
    logic randCredits = 1'b0;

    mulTop dut_i (
        .clk       (clk),
        .rstN      (rstN),
        .req       (req),
        .outCredit (outCredit),
        .resp      (resp),
        .inCredit  (inCredit)
    );

    bind resultCreditBuffer mulCredit_checker creditChk_i (
        .clk       (clk),
        .rstN      (rstN),
        .wrIn      (wrIn),
        .outCredit (outCredit),
        .resp      (resp),
        .inCredit  (inCredit),
        .fillCnt   (fillCnt),
        .doSend    (doSend)
    );

    always #2 clk = ~clk;

    always @(posedge clk) edgeCnt <= edgeCnt + 1;

    task automatic loadStim();
        int fd;
        int n;
        string line;
        logic [mulPkg::TAG_W-1:0]  t;
        logic [mulPkg::OP_W-1:0]   a;
        logic [mulPkg::OP_W-1:0]   b;
        logic [mulPkg::PROD_W-1:0] p;
        fd = $fopen("dv/mul_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/mul_stim.txt");
            errCnt++;
        end else begin
            while (!$feof(fd) && numVec < 64) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 2 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%h %h %h %h", t, a, b, p);
                    if (n == 4) begin
                        expTag[numVec]  = t;
                        expOp1[numVec]  = a;
                        expOp2[numVec]  = b;
                        expProd[numVec] = p;
                        numVec++;
                    end
                end
            end
            $fclose(fd);
            if (numVec == 0) begin
                $display("The stimulus file holds no operations");
                errCnt++;
            end
        end
    endtask

    // One clock step: collect returned credits, maybe free a consumer slot
    task automatic tick();
        @(posedge clk);
        #1;
        if (inCredit) upCredits++;
        outCredit = 1'b0;
        if (randCredits && (respCnt - creditsGiven) > 0 && (($random(seed) & 3) != 0)) begin
            outCredit = 1'b1;
            creditsGiven++;
        end
    endtask

    task automatic driveReq(input int n);
        req.valid = 1'b1;
        req.tag   = expTag[n];
        req.op1   = expOp1[n];
        req.op2   = expOp2[n];
        upCredits--;
        started   = 1'b1;
        if (n == 0) acceptEdge = edgeCnt + 1;    // Sampled at the next edge
    endtask

    always @(negedge clk) begin
        if (rstN) begin
            if (!started) begin
                assert (!resp.valid && !inCredit) else begin
                    $display("FAIL %0t: outputs active before the first request", $time);
                    errCnt++;
                end
            end
            if (resp.valid) begin
                respCnt++;
                assert (respCnt <= mulPkg::OUT_CREDITS + creditsSeen) else begin
                    $display("FAIL %0t: %0d results sent with only %0d credits granted",
                             $time, respCnt, mulPkg::OUT_CREDITS + creditsSeen);
                    errCnt++;
                end
                if (rxCnt >= numVec) begin
                    $display("Unexpected extra result with tag %h at %0t", resp.tag, $time);
                    errCnt++;
                end else begin
                    assert (resp.tag === expTag[rxCnt]) else begin
                        $display("FAIL %0t: result %0d tag %h, expected %h",
                                 $time, rxCnt, resp.tag, expTag[rxCnt]);
                        errCnt++;
                    end
                    assert (resp.product === expProd[rxCnt]) else begin
                        $display("FAIL %0t: %h * %h gave %h, expected %h", $time,
                                 expOp1[rxCnt], expOp2[rxCnt], resp.product, expProd[rxCnt]);
                        errCnt++;
                    end
                    if (rxCnt == 0) begin
                        assert (edgeCnt - acceptEdge == 4) else begin   // Pipeline latency
                            $display("FAIL %0t: isolated latency %0d cycles, expected 4",
                                     $time, edgeCnt - acceptEdge);
                            errCnt++;
                        end
                    end
                    rxCnt++;
                end
            end
            if (outCredit) creditsSeen++;
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (200 * (numVec + 1)) @(posedge clk);
        $display("Timeout: not all results arrived within %0d cycles", 200 * (numVec + 1));
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        seed      = 70998;
        rstN      = 1'b0;
        req       = '0;
        outCredit = 1'b0;
        loadStim();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;
        if (numVec > 0) begin
            repeat (4) tick();                       // Idle, outputs must stay low
            driveReq(0);                             // Alone, buffer empty
            tick();
            req.valid = 1'b0;
            while (rxCnt < 1) tick();
            randCredits = 1'b1;
            idx = 1;
            while (idx < numVec) begin
                tick();
                if (upCredits > 0) begin
                    driveReq(idx);
                    idx++;
                end else begin
                    req.valid = 1'b0;
                end
            end
            tick();
            req.valid = 1'b0;
            while (rxCnt < numVec) tick();
            repeat (4) tick();
            assert (upCredits == mulPkg::FIFO_DEPTH) else begin
                $display("FAIL %0t: upstream credits %0d at the end, expected %0d",
                         $time, upCredits, mulPkg::FIFO_DEPTH);
                errCnt++;
            end
        end
        chkFails = dut_i.resBuf_i.creditChk_i.failCnt;
        $display("Done: %0d results, %0d check errors, %0d assertion failures",
                 rxCnt, errCnt, chkFails);
        if (errCnt == 0 && chkFails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* dv/mul_stim.txt */
// tag op1 op2 product, all in hex
// product is the signed 64-bit result of op1 * op2
0 00000000 00000000 0000000000000000
1 00000001 FFFFFFFF FFFFFFFFFFFFFFFF
2 FFFFFFFF FFFFFFFF 0000000000000001
3 80000000 80000000 4000000000000000
4 80000000 FFFFFFFF 0000000080000000
5 7FFFFFFF 7FFFFFFF 3FFFFFFF00000001
6 7FFFFFFF 80000000 C000000080000000
7 AAAAAAAA 55555555 E38E38E371C71C72
8 55555555 55555555 1C71C71C38E38E39
9 AAAAAAAA AAAAAAAA 1C71C71CE38E38E4
A 00000000 12345678 0000000000000000
B 00000002 00000003 0000000000000006
C FFFFFFFE 00000003 FFFFFFFFFFFFFFFA
D 00010000 00010000 0000000100000000
E FFFF0000 00010000 FFFFFFFF00000000
F 12345678 00000010 0000000123456780
0 80000000 00000001 FFFFFFFF80000000
1 00001000 FFFFF000 FFFFFFFFFF000000
2 7FFFFFFF FFFFFFFF FFFFFFFF80000001
3 0000FFFF 0000FFFF 00000000FFFE0001
4 00000007 FFFFFFF9 FFFFFFFFFFFFFFCF
5 000000FF 000000FF 000000000000FE01

/* list.f */
verilog/mulPkg.sv
verilog/boothEncoder.sv
verilog/ppGenStage.sv
verilog/csaTreeStage.sv
verilog/finalAddStage.sv
verilog/resultCreditBuffer.sv
verilog/mulTop.sv
dv/mulCredit_checker.sv
dv/mulTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
		--top-module mulTb -Mdir obj_dir
	@out=$$(./obj_dir/VmulTb); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
